//--- Makefile
TOP = tb_cache
OBJ = obj_dir

all: run

$(OBJ)/V$(TOP): project.f design/*.sv test/*.sv
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -Mdir $(OBJ) -f project.f

run: $(OBJ)/V$(TOP)
	./$(OBJ)/V$(TOP) | tee sim.log
	grep -q "RESULT: PASS" sim.log

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f project.f
	verilator --lint-only --assert --top-module cache_top \
		design/cache_pkg.sv design/cache_way.sv design/way_select.sv \
		design/cache_ctrl.sv design/cache_top.sv

clean:
	rm -rf $(OBJ) sim.log

.PHONY: all run lint clean

//--- design/cache_ctrl.sv
`default_nettype none

module cache_ctrl #(
	parameter int WAY_NUM = 2,
	localparam int WAY_LEN = $clog2(WAY_NUM)
) (
	input logic clk,
	input logic rst,
	input cache_pkg::cache_req_t req,
	input logic req_valid,
	output logic req_ready,
	output logic resp_valid,
	output cache_pkg::word_t rdata,
	output cache_pkg::mem_wb_t wb,
	output logic wb_valid,
	input logic wb_ready,
	output cache_pkg::addr_t rd_addr,
	output logic rd_valid,
	input logic rd_ready,
	input logic rd_dvalid,
	input logic rd_dlast,
	input cache_pkg::word_t rd_data,
	output cache_pkg::way_cmd_t way_cmd,
	output logic way_re,
	output logic [WAY_NUM-1:0] way_we,
	input logic hit,
	input logic [WAY_LEN-1:0] hit_way,
	input cache_pkg::word_t hit_word,
	input logic [WAY_LEN-1:0] victim_way,
	input logic victim_valid,
	input logic victim_dirty,
	input cache_pkg::tag_t victim_tag,
	input cache_pkg::line_t victim_line
);
	import cache_pkg::*;

	localparam int BEAT_LEN = $clog2(WORDS_PER_LINE + 1);
	typedef logic [BEAT_LEN-1:0] beat_t;

	ctrl_state_t state;
	ctrl_state_t next_state;

	cache_req_t req_q;
	tag_t buf_tag;
	index_t buf_index;
	word_sel_t buf_word;

	logic [WAY_LEN-1:0] mb_way;
	tag_t mb_tag;
	line_t mb_line;

	beat_t beat_cnt;
	word_sel_t beat_sel;
	logic beat_hit;
	logic rd_sent;
	word_t merged;
	word_t rdata_q;

	assign buf_tag = req_q.addr[ADDR_LEN-1 -: TAG_LEN];
	assign buf_index = req_q.addr[OFFSET_LEN +: INDEX_LEN];
	assign buf_word = req_q.addr[OFFSET_LEN-1 -: $bits(word_sel_t)];

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		next_state = state;
		case (state)
			IDLE: begin
				if (req_valid) begin
					next_state = LOOKUP;
				end
			end
			LOOKUP: begin
				if (hit) begin
					next_state = IDLE;
				end else if (victim_valid && victim_dirty) begin
					next_state = WRITEBACK;
				end else begin
					next_state = REFILL;
				end
			end
			WRITEBACK: begin
				if (wb_ready) begin
					next_state = REFILL;
				end
			end
			REFILL: begin
				if (rd_dvalid && rd_dlast) begin
					next_state = RESPOND;
				end
			end
			default: next_state = IDLE;
		endcase
	end

	// request buffer, loaded on acceptance
	always_ff @(posedge clk) begin
		if (req_valid && req_ready) begin
			req_q <= req;
		end
	end

	// victim snapshot taken on a miss
	always_ff @(posedge clk) begin
		if (state == LOOKUP && !hit) begin
			mb_way <= victim_way;
			mb_tag <= victim_tag;
			mb_line <= victim_line;
		end
	end

	// refill request goes out once per miss
	always_ff @(posedge clk) begin
		if (rst) begin
			rd_sent <= 1'b0;
		end else if (state != REFILL) begin
			rd_sent <= 1'b0;
		end else if (rd_valid && rd_ready) begin
			rd_sent <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			beat_cnt <= '0;
		end else if (state != REFILL) begin
			beat_cnt <= '0;
		end else if (rd_dvalid) begin
			beat_cnt <= beat_cnt + beat_t'(1);
		end
	end

	assign beat_sel = word_sel_t'(beat_cnt);
	assign beat_hit = beat_sel == buf_word;

	// store bytes win over the incoming beat
	always_comb begin
		merged = rd_data;
		for (int b = 0; b < DATA_LEN / 8; b++) begin
			if (req_q.op && beat_hit && req_q.wstrb[b]) begin
				merged[b*8 +: 8] = req_q.wdata[b*8 +: 8];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (state == REFILL && rd_dvalid && beat_hit) begin
			rdata_q <= merged;
		end
	end

	// index comes straight from the port while idle
	always_comb begin
		way_cmd.index = (state == IDLE) ? req.addr[OFFSET_LEN +: INDEX_LEN] : buf_index;
		way_cmd.word_sel = (state == REFILL) ? beat_sel : buf_word;
		way_cmd.wdata = (state == REFILL) ? merged : req_q.wdata;
		way_cmd.wstrb = (state == REFILL) ? '1 : req_q.wstrb;
		way_cmd.tag = buf_tag;
		way_cmd.dirty = req_q.op;
		way_cmd.meta_we = (state == LOOKUP) || (state == REFILL && rd_dlast);
	end

	always_comb begin
		way_we = '0;
		if (state == LOOKUP && hit && req_q.op) begin
			way_we[hit_way] = 1'b1;
		end
		if (state == REFILL && rd_dvalid) begin
			way_we[mb_way] = 1'b1;
		end
	end

	assign way_re = (state == IDLE) && req_valid;

	assign req_ready = state == IDLE;
	assign resp_valid = (state == LOOKUP && hit) || state == RESPOND;
	assign rdata = (state == LOOKUP) ? hit_word : rdata_q;

	assign wb_valid = state == WRITEBACK;
	assign wb.addr = {mb_tag, buf_index, {OFFSET_LEN{1'b0}}};
	assign wb.line = mb_line;

	assign rd_valid = (state == REFILL) && !rd_sent;
	assign rd_addr = {buf_tag, buf_index, {OFFSET_LEN{1'b0}}};

	a_wb_rd_excl: assert property (@(posedge clk) disable iff (rst)
		!(wb_valid && rd_valid));

	// a beat never lands past the end of the line
	a_beat_bound: assert property (@(posedge clk) disable iff (rst)
		(state == REFILL && rd_dvalid) |-> beat_cnt < beat_t'(WORDS_PER_LINE));

endmodule

`default_nettype wire

//--- design/cache_pkg.sv
`default_nettype none

package cache_pkg;

	// address split is tag | index | offset
	localparam int ADDR_LEN = 32;
	localparam int DATA_LEN = 32;
	localparam int WORDS_PER_LINE = 2;
	localparam int OFFSET_LEN = 3;
	localparam int INDEX_LEN = 4;
	localparam int TAG_LEN = ADDR_LEN - INDEX_LEN - OFFSET_LEN;

	typedef logic [ADDR_LEN-1:0] addr_t;
	typedef logic [TAG_LEN-1:0] tag_t;
	typedef logic [INDEX_LEN-1:0] index_t;
	typedef logic [DATA_LEN-1:0] word_t;
	typedef logic [DATA_LEN/8-1:0] strb_t;
	// word 0 sits in the low half
	typedef logic [WORDS_PER_LINE*DATA_LEN-1:0] line_t;
	typedef logic [$clog2(WORDS_PER_LINE)-1:0] word_sel_t;

	typedef struct packed {
		logic op;
		addr_t addr;
		strb_t wstrb;
		word_t wdata;
	} cache_req_t;

	// same command goes to every way, way_we picks the target
	typedef struct packed {
		index_t index;
		word_sel_t word_sel;
		word_t wdata;
		strb_t wstrb;
		tag_t tag;
		logic dirty;
		logic meta_we;
	} way_cmd_t;

	typedef struct packed {
		logic valid;
		logic dirty;
		tag_t tag;
		line_t line;
		logic hit;
	} way_out_t;

	typedef struct packed {
		addr_t addr;
		line_t line;
	} mem_wb_t;

	typedef enum logic [2:0] {
		IDLE,
		LOOKUP,
		WRITEBACK,
		REFILL,
		RESPOND
	} ctrl_state_t;

endpackage

`default_nettype wire

//--- design/cache_top.sv
`default_nettype none

module cache_top #(
	parameter int WAY_NUM = 2
) (
	input logic clk,
	input logic rst,
	input cache_pkg::cache_req_t req,
	input logic req_valid,
	output logic req_ready,
	output logic resp_valid,
	output cache_pkg::word_t rdata,
	output cache_pkg::mem_wb_t wb,
	output logic wb_valid,
	input logic wb_ready,
	output cache_pkg::addr_t rd_addr,
	output logic rd_valid,
	input logic rd_ready,
	input logic rd_dvalid,
	input logic rd_dlast,
	input cache_pkg::word_t rd_data
);
	import cache_pkg::*;

	localparam int WAY_LEN = $clog2(WAY_NUM);

	way_cmd_t way_cmd;
	logic way_re;
	logic [WAY_NUM-1:0] way_we;
	way_out_t way_outs [WAY_NUM];

	logic hit;
	logic [WAY_LEN-1:0] hit_way;
	word_t hit_word;
	logic [WAY_LEN-1:0] victim_way;
	logic victim_valid;
	logic victim_dirty;
	tag_t victim_tag;
	line_t victim_line;

	cache_ctrl #(
		.WAY_NUM(WAY_NUM)
	) u_ctrl (
		.clk(clk),
		.rst(rst),
		.req(req),
		.req_valid(req_valid),
		.req_ready(req_ready),
		.resp_valid(resp_valid),
		.rdata(rdata),
		.wb(wb),
		.wb_valid(wb_valid),
		.wb_ready(wb_ready),
		.rd_addr(rd_addr),
		.rd_valid(rd_valid),
		.rd_ready(rd_ready),
		.rd_dvalid(rd_dvalid),
		.rd_dlast(rd_dlast),
		.rd_data(rd_data),
		.way_cmd(way_cmd),
		.way_re(way_re),
		.way_we(way_we),
		.hit(hit),
		.hit_way(hit_way),
		.hit_word(hit_word),
		.victim_way(victim_way),
		.victim_valid(victim_valid),
		.victim_dirty(victim_dirty),
		.victim_tag(victim_tag),
		.victim_line(victim_line)
	);

	// the buffered request tag rides along in the command
	for (genvar i = 0; i < WAY_NUM; i++) begin : g_way
		cache_way u_way (
			.clk(clk),
			.rst(rst),
			.way_cmd(way_cmd),
			.way_re(way_re),
			.way_we(way_we[i]),
			.req_tag(way_cmd.tag),
			.way_out(way_outs[i])
		);
	end

	way_select #(
		.WAY_NUM(WAY_NUM)
	) u_sel (
		.clk(clk),
		.rst(rst),
		.way_outs(way_outs),
		.word_sel(way_cmd.word_sel),
		.hit(hit),
		.hit_way(hit_way),
		.hit_word(hit_word),
		.victim_way(victim_way),
		.victim_valid(victim_valid),
		.victim_dirty(victim_dirty),
		.victim_tag(victim_tag),
		.victim_line(victim_line)
	);

endmodule

`default_nettype wire

//--- design/cache_way.sv
`default_nettype none

module cache_way (
	input logic clk,
	input logic rst,
	input cache_pkg::way_cmd_t way_cmd,
	input logic way_re,
	input logic way_we,
	input cache_pkg::tag_t req_tag,
	output cache_pkg::way_out_t way_out
);
	import cache_pkg::*;

	localparam int SET_NUM = 1 << INDEX_LEN;

	logic [SET_NUM-1:0] valid;
	logic [SET_NUM-1:0] dirty;
	tag_t tags [SET_NUM];
	word_t data [SET_NUM][WORDS_PER_LINE];

	// registered copy of the addressed set
	logic valid_q;
	logic dirty_q;
	tag_t tag_q;
	line_t line_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			valid <= '0;
		end else if (way_we && way_cmd.meta_we) begin
			valid[way_cmd.index] <= 1'b1;
		end
	end

	// tag and dirty only move with the meta flag
	always_ff @(posedge clk) begin
		if (way_we && way_cmd.meta_we) begin
			dirty[way_cmd.index] <= way_cmd.dirty;
			tags[way_cmd.index] <= way_cmd.tag;
		end
	end

	always_ff @(posedge clk) begin
		if (way_we) begin
			for (int b = 0; b < DATA_LEN / 8; b++) begin
				if (way_cmd.wstrb[b]) begin
					data[way_cmd.index][way_cmd.word_sel][b*8 +: 8] <= way_cmd.wdata[b*8 +: 8];
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			valid_q <= 1'b0;
		end else if (way_re) begin
			valid_q <= valid[way_cmd.index];
		end
	end

	always_ff @(posedge clk) begin
		if (way_re) begin
			dirty_q <= dirty[way_cmd.index];
			tag_q <= tags[way_cmd.index];
			for (int w = 0; w < WORDS_PER_LINE; w++) begin
				line_q[w*DATA_LEN +: DATA_LEN] <= data[way_cmd.index][w];
			end
		end
	end

	assign way_out.valid = valid_q;
	assign way_out.dirty = dirty_q;
	assign way_out.tag = tag_q;
	assign way_out.line = line_q;
	assign way_out.hit = valid_q && (tag_q == req_tag);

endmodule

`default_nettype wire

//--- design/way_select.sv
`default_nettype none

module way_select #(
	parameter int WAY_NUM = 2,
	localparam int WAY_LEN = $clog2(WAY_NUM)
) (
	input logic clk,
	input logic rst,
	input cache_pkg::way_out_t way_outs [WAY_NUM],
	input cache_pkg::word_sel_t word_sel,
	output logic hit,
	output logic [WAY_LEN-1:0] hit_way,
	output cache_pkg::word_t hit_word,
	output logic [WAY_LEN-1:0] victim_way,
	output logic victim_valid,
	output logic victim_dirty,
	output cache_pkg::tag_t victim_tag,
	output cache_pkg::line_t victim_line
);
	import cache_pkg::*;

	logic [15:0] lfsr;
	logic [WAY_NUM-1:0] hits;
	logic free_found;
	line_t hit_line;

	// x^16 + x^14 + x^13 + x^11, free running
	always_ff @(posedge clk) begin
		if (rst) begin
			lfsr <= 16'hace1;
		end else begin
			lfsr <= {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
		end
	end

	always_comb begin
		hit_way = '0;
		for (int i = 0; i < WAY_NUM; i++) begin
			hits[i] = way_outs[i].hit;
			if (way_outs[i].hit) begin
				hit_way = WAY_LEN'(i);
			end
		end
	end

	assign hit = |hits;
	assign hit_line = way_outs[hit_way].line;
	assign hit_word = hit_line[word_sel*DATA_LEN +: DATA_LEN];

	// an empty way beats the random pick
	always_comb begin
		victim_way = lfsr[WAY_LEN-1:0];
		free_found = 1'b0;
		for (int i = 0; i < WAY_NUM; i++) begin
			if (!free_found && !way_outs[i].valid) begin
				victim_way = WAY_LEN'(i);
				free_found = 1'b1;
			end
		end
	end

	assign victim_valid = way_outs[victim_way].valid;
	assign victim_dirty = way_outs[victim_way].dirty;
	assign victim_tag = way_outs[victim_way].tag;
	assign victim_line = way_outs[victim_way].line;

	// tags within a set stay unique across the ways
	a_onehot_hit: assert property (@(posedge clk) disable iff (rst)
		$onehot0(hits));

endmodule

`default_nettype wire

//--- project.f
design/cache_pkg.sv
design/cache_way.sv
design/way_select.sv
design/cache_ctrl.sv
design/cache_top.sv
test/tb_mem.sv
test/tb_cache.sv

//--- test/tb_cache.sv
`default_nettype none

module tb_cache;
	import cache_pkg::*;

	localparam int PERIOD = 20;
	localparam int RST_CYCLES = 8;
	// write-back plus refill with every memory delay at its longest
	localparam int MISS_BOUND = 40;
	localparam int ANY = 0;
	localparam int HIT = 1;
	localparam int MISS = 2;

	typedef struct {
		string name;
		cache_req_t req;
		int kind;
	} entry_t;

	logic clk;
	logic rst;
	cache_req_t req;
	logic req_valid;
	logic req_ready;
	logic resp_valid;
	word_t rdata;
	mem_wb_t wb;
	logic wb_valid;
	logic wb_ready;
	addr_t rd_addr;
	logic rd_valid;
	logic rd_ready;
	logic rd_dvalid;
	logic rd_dlast;
	word_t rd_data;

	entry_t entries[$];
	// golden memory, bytes that were stored
	logic [7:0] gold [addr_t];
	// lines written since their last write-back
	logic dirty_lines [addr_t];
	// request in flight, for the refill address check
	string cur_name;
	addr_t cur_line;
	logic table_done;
	int checks;
	int value_errors;
	int other_errors;

	cache_top #(
		.WAY_NUM(2)
	) UUT (.*);

	tb_mem #(
		.SEED(23918)
	) mem_model (.*);

	initial clk = 1'b0;
	always #(PERIOD / 2) clk = ~clk;

	function automatic word_t fill_word(input addr_t a);
		return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]} ^ 32'h5a5a_a5a5;
	endfunction

	function automatic word_t gold_word(input addr_t a);
		word_t w;
		addr_t base;
		base = {a[ADDR_LEN-1:2], 2'b00};
		w = fill_word(base);
		for (int b = 0; b < DATA_LEN / 8; b++) begin
			if (gold.exists(base + addr_t'(b))) begin
				w[b*8 +: 8] = gold[base + addr_t'(b)];
			end
		end
		return w;
	endfunction

	task automatic gold_write(input cache_req_t r);
		addr_t base;
		base = {r.addr[ADDR_LEN-1:2], 2'b00};
		for (int b = 0; b < DATA_LEN / 8; b++) begin
			if (r.wstrb[b]) begin
				gold[base + addr_t'(b)] = r.wdata[b*8 +: 8];
			end
		end
		// write-allocate leaves the line dirty in the cache
		dirty_lines[{r.addr[ADDR_LEN-1:OFFSET_LEN], {OFFSET_LEN{1'b0}}}] = 1'b1;
	endtask

	task automatic add_entry(input string name, input logic op, input addr_t addr,
		input strb_t wstrb, input word_t wdata, input int kind);
		entry_t e;
		e.name = name;
		e.req = '{op, addr, wstrb, wdata};
		e.kind = kind;
		entries.push_back(e);
	endtask

	task automatic load_table();
		add_entry("rd_cold", 1'b0, 32'h0000_1000, 4'h0, 32'h0, MISS);
		add_entry("rd_again", 1'b0, 32'h0000_1000, 4'h0, 32'h0, HIT);
		add_entry("rd_word1", 1'b0, 32'h0000_1004, 4'h0, 32'h0, HIT);
		add_entry("wr_hit", 1'b1, 32'h0000_1004, 4'h3, 32'hdead_beef, HIT);
		add_entry("rd_wr_hit", 1'b0, 32'h0000_1004, 4'h0, 32'h0, HIT);
		add_entry("wr_miss", 1'b1, 32'h0000_2008, 4'hc, 32'h1234_5678, MISS);
		add_entry("rd_wr_miss", 1'b0, 32'h0000_2008, 4'h0, 32'h0, HIT);
		add_entry("rd_wr_miss_w1", 1'b0, 32'h0000_200c, 4'h0, 32'h0, HIT);
		add_entry("wr_miss_full", 1'b1, 32'h0000_3000, 4'hf, 32'ha5a5_0001, MISS);
		add_entry("evict_4000", 1'b0, 32'h0000_4000, 4'h0, 32'h0, MISS);
		add_entry("evict_5000", 1'b0, 32'h0000_5000, 4'h0, 32'h0, MISS);
		add_entry("evict_6000", 1'b0, 32'h0000_6000, 4'h0, 32'h0, MISS);
		add_entry("wr_evict_7004", 1'b1, 32'h0000_7004, 4'h5, 32'h00c3_00c3, MISS);
		add_entry("rd_7004", 1'b0, 32'h0000_7004, 4'h0, 32'h0, HIT);
		add_entry("back_1004", 1'b0, 32'h0000_1004, 4'h0, 32'h0, ANY);
		add_entry("back_3000", 1'b0, 32'h0000_3000, 4'h0, 32'h0, ANY);
		add_entry("back_2008", 1'b0, 32'h0000_2008, 4'h0, 32'h0, HIT);
		add_entry("back_4000", 1'b0, 32'h0000_4000, 4'h0, 32'h0, ANY);
		add_entry("rd_set5", 1'b0, 32'h0001_02a8, 4'h0, 32'h0, MISS);
		add_entry("rd_high", 1'b0, 32'hfedc_ba98, 4'h0, 32'h0, MISS);
		add_entry("wr_high", 1'b1, 32'hfedc_ba9c, 4'h8, 32'h7700_0000, HIT);
		add_entry("rd_high_w1", 1'b0, 32'hfedc_ba9c, 4'h0, 32'h0, HIT);
		add_entry("evict_8000", 1'b0, 32'h0000_8000, 4'h0, 32'h0, MISS);
		add_entry("evict_9000", 1'b0, 32'h0000_9000, 4'h0, 32'h0, MISS);
		add_entry("back_7004", 1'b0, 32'h0000_7004, 4'h0, 32'h0, ANY);
		add_entry("back_1000", 1'b0, 32'h0000_1000, 4'h0, 32'h0, ANY);
		add_entry("back_3004", 1'b0, 32'h0000_3004, 4'h0, 32'h0, ANY);
	endtask

	task automatic check_writeback();
		line_t expected;
		expected = {gold_word(wb.addr + addr_t'(4)), gold_word(wb.addr)};
		checks++;
		assert (dirty_lines.exists(wb.addr)) else begin
			$display("line %h written back without a store since it was loaded", wb.addr);
			other_errors++;
		end
		dirty_lines.delete(wb.addr);
		assert (wb.line === expected) else begin
			$display("FAIL writeback_%h expected %h actual %h", wb.addr, expected, wb.line);
			value_errors++;
		end
	endtask

	task automatic check_refill_addr();
		checks++;
		assert (rd_addr === cur_line) else begin
			$display("FAIL %s_refill expected %h actual %h", cur_name, cur_line, rd_addr);
			value_errors++;
		end
	endtask

	// one negedge per completed write-back
	always @(negedge clk) begin
		if (!rst && wb_valid && wb_ready) begin
			check_writeback();
		end
	end

	// one negedge per accepted refill request
	always @(negedge clk) begin
		if (!rst && rd_valid && rd_ready) begin
			check_refill_addr();
		end
	end

	// starts and ends just after a rising edge, with the DUT idle
	task automatic run_entry(input entry_t e);
		word_t expected;
		int latency;
		expected = gold_word(e.req.addr);
		if (e.req.op) begin
			gold_write(e.req);
		end
		cur_name = e.name;
		cur_line = {e.req.addr[ADDR_LEN-1:OFFSET_LEN], {OFFSET_LEN{1'b0}}};
		req = e.req;
		req_valid = 1'b1;
		@(negedge clk);
		while (!req_ready) begin
			@(negedge clk);
		end
		@(posedge clk);
		#1;
		req_valid = 1'b0;
		req = '0;
		latency = 0;
		do begin
			@(negedge clk);
			latency++;
			checks++;
			assert (!req_ready) else begin
				$display("%s: req_ready high while the request is in flight", e.name);
				other_errors++;
			end
		end while (!resp_valid);
		if (!e.req.op) begin
			checks++;
			assert (rdata === expected) else begin
				$display("FAIL %s expected %h actual %h", e.name, expected, rdata);
				value_errors++;
			end
		end
		if (e.kind == HIT) begin
			checks++;
			assert (latency == 1) else begin
				$display("FAIL %s expected latency %0d actual %0d", e.name, 1, latency);
				value_errors++;
			end
		end else if (e.kind == MISS) begin
			checks++;
			assert (latency > 1) else begin
				$display("%s: answered in one cycle although it has to miss", e.name);
				other_errors++;
			end
		end
		@(posedge clk);
		#1;
	endtask

	initial begin
		rst = 1'b1;
		req = '0;
		req_valid = 1'b0;
		checks = 0;
		value_errors = 0;
		other_errors = 0;
		cur_name = "reset";
		cur_line = '0;
		table_done = 1'b0;
		load_table();
		table_done = 1'b1;
		repeat (RST_CYCLES) @(posedge clk);
		#1;
		rst = 1'b0;
		@(negedge clk);
		checks++;
		assert (req_ready && !resp_valid && !wb_valid && !rd_valid) else begin
			$display("outputs not idle after reset: req_ready %b resp_valid %b",
				req_ready, resp_valid);
			$display("wb_valid %b rd_valid %b", wb_valid, rd_valid);
			other_errors++;
		end
		@(posedge clk);
		#1;
		foreach (entries[i]) begin
			run_entry(entries[i]);
		end
		$display("checks %0d, value errors %0d, other errors %0d",
			checks, value_errors, other_errors);
		if (value_errors + other_errors == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

	// bound scales with the number of table entries
	initial begin
		wait (table_done);
		#((RST_CYCLES + 2 + entries.size() * MISS_BOUND) * PERIOD);
		$display("timeout, the DUT stopped answering before the last request");
		$display("checks %0d, value errors %0d, other errors %0d",
			checks, value_errors, other_errors);
		$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- test/tb_mem.sv
`default_nettype none

module tb_mem #(
	parameter int SEED = 1
) (
	input logic clk,
	input logic rst,
	input cache_pkg::mem_wb_t wb,
	input logic wb_valid,
	output logic wb_ready,
	input cache_pkg::addr_t rd_addr,
	input logic rd_valid,
	output logic rd_ready,
	output logic rd_dvalid,
	output logic rd_dlast,
	output cache_pkg::word_t rd_data
);
	import cache_pkg::*;

	// backing store keyed by line address
	line_t lines [addr_t];

	// contents of memory that was never written
	function automatic word_t fill_word(input addr_t a);
		return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]} ^ 32'h5a5a_a5a5;
	endfunction

	function automatic line_t read_line(input addr_t a);
		if (lines.exists(a)) begin
			return lines[a];
		end
		return {fill_word(a + 32'd4), fill_word(a)};
	endfunction

	// land just after the next rising edge
	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic idle_cycles(input int max_wait);
		int n;
		n = $urandom_range(max_wait, 0);
		repeat (n) next_cycle();
	endtask

	initial begin
		line_t fetched;
		wb_ready = 1'b0;
		rd_ready = 1'b0;
		rd_dvalid = 1'b0;
		rd_dlast = 1'b0;
		rd_data = '0;
		void'($urandom(SEED));
		forever begin
			@(negedge clk);
			if (!rst && wb_valid) begin
				next_cycle();
				idle_cycles(3);
				wb_ready = 1'b1;
				lines[wb.addr] = wb.line;
				next_cycle();
				wb_ready = 1'b0;
			end else if (!rst && rd_valid) begin
				fetched = read_line(rd_addr);
				next_cycle();
				idle_cycles(3);
				rd_ready = 1'b1;
				next_cycle();
				rd_ready = 1'b0;
				// word 0 first, gaps allowed between beats
				for (int w = 0; w < WORDS_PER_LINE; w++) begin
					idle_cycles(2);
					rd_dvalid = 1'b1;
					rd_dlast = (w == WORDS_PER_LINE - 1);
					rd_data = fetched[w*DATA_LEN +: DATA_LEN];
					next_cycle();
					rd_dvalid = 1'b0;
					rd_dlast = 1'b0;
				end
			end
		end
	end

endmodule

`default_nettype wire
